// File: Makefile
TOP = tb_free_xor_garbler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/free_xor_garbler.sv
// Free-XOR garbling core
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

module free_xor_garbler (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`GC_APB_ADDR_W-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`GC_WORD_W-1:0]     pwdata,
	output logic [`GC_WORD_W-1:0]     prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      start,
	output logic                      busy,
	output gc_pkg::stream_tag_e       tag,
	output logic [`GC_IDX_W-1:0]      index0,
	output logic [`GC_LABEL_W-1:0]    data0,
	output logic [`GC_LABEL_W-1:0]    data1
);
	logic                   gen_en, il_we, gl_we;
	logic [`GC_LABEL_W-1:0] gen_label, il_wdata, gl_wdata;
	logic [`GC_IDX_W-1:0]   il_waddr, il_raddr_a, il_raddr_b;
	logic [`GC_IDX_W-1:0]   gl_waddr, gl_raddr_a, gl_raddr_b;
	logic [`GC_LABEL_W-1:0] il_rdata_a, il_rdata_b, gl_rdata_a, gl_rdata_b;

	gate_read_if rd_if ();

	netlist_regs u_netlist (.clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr, .rd(rd_if.store));

	label_gen u_label_gen (.clk, .rst, .en(gen_en), .label(gen_label));

	label_ram #(.DEPTH(`GC_MAX_INPUTS)) u_input_labels (.clk, .we(il_we), .waddr(il_waddr),
		.wdata(il_wdata), .raddr_a(il_raddr_a), .rdata_a(il_rdata_a),
		.raddr_b(il_raddr_b), .rdata_b(il_rdata_b));

	label_ram #(.DEPTH(`GC_MAX_GATES)) u_gate_labels (.clk, .we(gl_we), .waddr(gl_waddr),
		.wdata(gl_wdata), .raddr_a(gl_raddr_a), .rdata_a(gl_rdata_a),
		.raddr_b(gl_raddr_b), .rdata_b(gl_rdata_b));

	garble_ctrl u_ctrl (.clk, .rst, .start, .rd(rd_if.ctrl), .gen_en, .gen_label,
		.il_we, .il_waddr, .il_wdata, .il_raddr_a, .il_raddr_b, .il_rdata_a, .il_rdata_b,
		.gl_we, .gl_waddr, .gl_wdata, .gl_raddr_a, .gl_raddr_b, .gl_rdata_a, .gl_rdata_b,
		.busy, .tag, .index0, .data0, .data1);
endmodule

`default_nettype wire

// File: hdl/garble_ctrl.sv
// Free-XOR garbling controller
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

module garble_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	gate_read_if.ctrl              rd,
	output logic                   gen_en,
	input  logic [`GC_LABEL_W-1:0] gen_label,
	output logic                   il_we,
	output logic [`GC_IDX_W-1:0]   il_waddr,
	output logic [`GC_LABEL_W-1:0] il_wdata,
	output logic [`GC_IDX_W-1:0]   il_raddr_a,
	output logic [`GC_IDX_W-1:0]   il_raddr_b,
	input  logic [`GC_LABEL_W-1:0] il_rdata_a,
	input  logic [`GC_LABEL_W-1:0] il_rdata_b,
	output logic                   gl_we,
	output logic [`GC_IDX_W-1:0]   gl_waddr,
	output logic [`GC_LABEL_W-1:0] gl_wdata,
	output logic [`GC_IDX_W-1:0]   gl_raddr_a,
	output logic [`GC_IDX_W-1:0]   gl_raddr_b,
	input  logic [`GC_LABEL_W-1:0] gl_rdata_a,
	input  logic [`GC_LABEL_W-1:0] gl_rdata_b,
	output logic                   busy,
	output gc_pkg::stream_tag_e    tag,
	output logic [`GC_IDX_W-1:0]   index0,
	output logic [`GC_LABEL_W-1:0] data0,
	output logic [`GC_LABEL_W-1:0] data1
);
	localparam int MASK_AW = $clog2(`GC_LABEL_W);

	gc_pkg::ctrl_state_e    state, state_d;
	gc_pkg::stream_tag_e    tag_d;
	logic [`GC_IDX_W-1:0]   in_cnt, gate_cnt, gate_cnt_d, out_cnt, index0_d;
	logic [`GC_LABEL_W-1:0] r_q, r_new, mask_q, op_a, op_b, result, data0_d, data1_d;
	logic                   has_gates, last_input, last_gate, is_output;

	assign busy         = state != gc_pkg::IDLE;
	assign rd.busy      = busy;
	assign rd.gate_addr = gate_cnt_d;  // Word lands as the counter takes this value
	assign r_new        = {gen_label[`GC_LABEL_W-1:1], 1'b1};  // Point bit of R is one

	assign has_gates  = rd.gate_count != '0;
	assign last_input = in_cnt == rd.input_count - 1'b1;
	assign last_gate  = gate_cnt == rd.gate_count - 1'b1;
	assign is_output  = rd.gate_word.gate.is_output;

	// Both memories see the operand indexes, the flags pick one in EVAL
	assign il_raddr_a = rd.gate_word.gate.in0;
	assign gl_raddr_a = rd.gate_word.gate.in0;
	assign il_raddr_b = rd.gate_word.gate.in1;
	assign gl_raddr_b = rd.gate_word.gate.in1;
	assign op_a = rd.gate_word.gate.in0_is_input ? il_rdata_a : gl_rdata_a;
	assign op_b = rd.gate_word.gate.in1_is_input ? il_rdata_b : gl_rdata_b;

	always_comb begin
		case (rd.gate_word.gate.op)
			gc_pkg::GATE_XOR:  result = op_a ^ op_b;
			gc_pkg::GATE_XNOR: result = op_a ^ op_b ^ r_q;
			default:           result = op_a ^ r_q;  // NOT
		endcase
	end

	assign gen_en   = (state == gc_pkg::GEN_R) || (state == gc_pkg::INPUTS);
	assign il_we    = state == gc_pkg::INPUTS;
	assign il_waddr = in_cnt;
	assign il_wdata = gen_label;
	assign gl_we    = state == gc_pkg::EVAL;
	assign gl_waddr = gate_cnt;
	assign gl_wdata = result;

	always_comb begin
		state_d    = state;
		gate_cnt_d = gate_cnt;
		tag_d      = gc_pkg::TAG_NONE;
		index0_d   = gate_cnt;
		data0_d    = result;
		data1_d    = result ^ r_q;  // One-label of the record
		case (state)
			gc_pkg::IDLE: begin
				gate_cnt_d = '0;  // Prefetch gate 0 during key and input setup
				if (start)
					state_d = gc_pkg::GEN_R;
			end
			gc_pkg::GEN_R: begin
				tag_d    = gc_pkg::TAG_KEY;
				index0_d = '0;
				data0_d  = r_new;
				data1_d  = '0;
				if (rd.input_count != '0)
					state_d = gc_pkg::INPUTS;
				else
					state_d = has_gates ? gc_pkg::READ : gc_pkg::MASKS;
			end
			gc_pkg::INPUTS: begin
				tag_d    = gc_pkg::TAG_INPUT;
				index0_d = in_cnt;
				data0_d  = gen_label;
				data1_d  = gen_label ^ r_q;
				if (last_input)
					state_d = has_gates ? gc_pkg::READ : gc_pkg::MASKS;
			end
			gc_pkg::READ: state_d = gc_pkg::EVAL;  // Operand labels in flight
			gc_pkg::EVAL: begin
				tag_d = gc_pkg::TAG_GATE;
				if (last_gate)
					state_d = gc_pkg::MASKS;
				else begin
					gate_cnt_d = gate_cnt + 1'b1;
					state_d    = gc_pkg::READ;
				end
			end
			gc_pkg::MASKS: begin
				tag_d    = gc_pkg::TAG_MASK;
				index0_d = rd.output_count;
				data0_d  = mask_q;
				data1_d  = '0;
				state_d  = gc_pkg::IDLE;
			end
			default: state_d = gc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= gc_pkg::IDLE;
			tag      <= gc_pkg::TAG_NONE;
			in_cnt   <= '0;
			gate_cnt <= '0;
			out_cnt  <= '0;
		end else begin
			state    <= state_d;
			tag      <= tag_d;
			gate_cnt <= gate_cnt_d;
			if (state == gc_pkg::IDLE) begin
				in_cnt  <= '0;
				out_cnt <= '0;
			end else if (state == gc_pkg::INPUTS)
				in_cnt <= in_cnt + 1'b1;
			else if (state == gc_pkg::EVAL && is_output)
				out_cnt <= out_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		index0 <= index0_d;
		data0  <= data0_d;
		data1  <= data1_d;
		if (state == gc_pkg::GEN_R) begin
			r_q    <= r_new;
			mask_q <= '0;
		end else if (state == gc_pkg::EVAL && is_output && out_cnt < `GC_LABEL_W)
			mask_q[out_cnt[MASK_AW-1:0]] <= result[0];  // Output order, bit 0 first
	end

	// Only the MASK record may leave as busy drops
	a_quiet_idle: assert property (@(posedge clk) disable iff (rst)
		(!busy && !$fell(busy)) |-> tag == gc_pkg::TAG_NONE)
		else $error("stream record outside a run");

	a_gate_range: assert property (@(posedge clk) disable iff (rst)
		(state inside {gc_pkg::READ, gc_pkg::EVAL}) |-> gate_cnt < rd.gate_count)
		else $error("gate counter past gate count");
endmodule

`default_nettype wire

// File: hdl/gate_read_if.sv
// Gate fetch link
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

interface gate_read_if;
	logic [`GC_IDX_W-1:0]  gate_addr;
	gc_pkg::netlist_word_u gate_word;    // One cycle after gate_addr
	logic [`GC_IDX_W-1:0]  input_count;
	logic [`GC_IDX_W-1:0]  gate_count;
	logic [`GC_IDX_W-1:0]  output_count;
	logic                  busy;         // Run in progress, store refuses writes

	modport store (input gate_addr, input busy, output gate_word,
		output input_count, output gate_count, output output_count);

	modport ctrl (output gate_addr, output busy, input gate_word,
		input input_count, input gate_count, input output_count);
endinterface

`default_nettype wire

// File: hdl/gc_defines.svh
// Garbling core parameters
`ifndef GC_DEFINES_SVH
`define GC_DEFINES_SVH

`define GC_LABEL_W        32
`define GC_IDX_W          6
`define GC_MAX_INPUTS     64
`define GC_MAX_GATES      64

// APB map, byte addresses
`define GC_APB_ADDR_W     12
`define GC_WORD_W         32
`define GC_ADDR_SIZES     12'h000
`define GC_ADDR_GATE_BASE 12'h100

`define GC_LFSR_SEED      32'h1D87_2B41
`define GC_LFSR_POLY      32'h8020_0003  // Taps 32, 22, 2, 1

`endif

// File: hdl/gc_pkg.sv
// Garbling core types
`default_nettype none
`include "gc_defines.svh"

package gc_pkg;

	typedef enum logic [1:0] {
		GATE_XOR  = 2'd0,
		GATE_XNOR = 2'd1,
		GATE_NOT  = 2'd2
	} gate_op_e;

	// Record tags on the output stream
	typedef enum logic [2:0] {
		TAG_NONE  = 3'b000,
		TAG_KEY   = 3'b001,
		TAG_GATE  = 3'b010,
		TAG_MASK  = 3'b011,
		TAG_INPUT = 3'b101
	} stream_tag_e;

	typedef enum logic [2:0] {IDLE, GEN_R, INPUTS, READ, EVAL, MASKS} ctrl_state_e;

	typedef struct packed {
		logic [`GC_WORD_W-3*`GC_IDX_W-1:0] rsvd;
		logic [`GC_IDX_W-1:0]              output_count;
		logic [`GC_IDX_W-1:0]              gate_count;
		logic [`GC_IDX_W-1:0]              input_count;  // Bits 5:0
	} sizes_view_t;

	typedef struct packed {
		logic [`GC_WORD_W-2*`GC_IDX_W-6:0] rsvd;
		logic                              is_output;
		logic                              in1_is_input;
		logic [`GC_IDX_W-1:0]              in1;
		logic                              in0_is_input;
		logic [`GC_IDX_W-1:0]              in0;
		gate_op_e                          op;  // Bits 1:0
	} gate_view_t;

	// Same APB word, layout picked by address
	typedef union packed {
		sizes_view_t sizes;
		gate_view_t  gate;
	} netlist_word_u;

endpackage

`default_nettype wire

// File: hdl/label_gen.sv
// Pseudo-random label source
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

module label_gen (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en,
	output logic [`GC_LABEL_W-1:0] label
);
	logic [`GC_LABEL_W-1:0] lfsr_q;

	// Galois step, shift right and fold the dropped bit back through the taps
	assign label = {1'b0, lfsr_q[`GC_LABEL_W-1:1]} ^
		({`GC_LABEL_W{lfsr_q[0]}} & `GC_LFSR_POLY);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			lfsr_q <= `GC_LFSR_SEED;
		else if (en)
			lfsr_q <= label;  // Label shown this cycle becomes the new state
	end
endmodule

`default_nettype wire

// File: hdl/label_ram.sv
// Label memory, one write and two read ports
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

module label_ram #(
	parameter int DEPTH = `GC_MAX_GATES,
	parameter int AW    = `GC_IDX_W,
	parameter int DW    = `GC_LABEL_W
) (
	input  logic          clk,
	input  logic          we,
	input  logic [AW-1:0] waddr,
	input  logic [DW-1:0] wdata,
	input  logic [AW-1:0] raddr_a,
	output logic [DW-1:0] rdata_a,
	input  logic [AW-1:0] raddr_b,
	output logic [DW-1:0] rdata_b
);
	logic [DW-1:0] mem [DEPTH];

	// Read before write on a shared address
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata_a <= mem[raddr_a];
		rdata_b <= mem[raddr_b];
	end

	a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr))
		else $error("label_ram write with unknown address");
endmodule

`default_nettype wire

// File: hdl/netlist_regs.sv
// APB netlist store
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

module netlist_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`GC_APB_ADDR_W-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`GC_WORD_W-1:0]     pwdata,
	output logic [`GC_WORD_W-1:0]     prdata,
	output logic                      pready,
	output logic                      pslverr,
	gate_read_if.store                rd
);
	localparam int GATE_SPAN = 4 * `GC_MAX_GATES;

	gc_pkg::netlist_word_u     sizes_q;
	gc_pkg::netlist_word_u     wr_word;
	gc_pkg::netlist_word_u     gate_mem [`GC_MAX_GATES];
	logic [`GC_APB_ADDR_W-1:0] gate_off;
	logic [`GC_IDX_W-1:0]      gate_num;
	logic                      access;
	logic                      hit_sizes;
	logic                      hit_gate;
	logic                      wr_en;

	assign access    = psel & penable;
	assign gate_off  = paddr - `GC_ADDR_GATE_BASE;
	assign gate_num  = gate_off[`GC_IDX_W+1:2];
	assign hit_sizes = paddr == `GC_ADDR_SIZES;
	assign hit_gate  = (paddr >= `GC_ADDR_GATE_BASE) && (paddr[1:0] == 2'b00) &&
		(gate_off < `GC_APB_ADDR_W'(GATE_SPAN));
	assign wr_word   = pwdata;

	assign pready  = 1'b1;  // Zero wait states
	assign pslverr = access & (~(hit_sizes | hit_gate) | (pwrite & rd.busy));
	assign wr_en   = access & pwrite & ~pslverr;

	always_comb begin
		if (hit_sizes)
			prdata = sizes_q;
		else if (hit_gate)
			prdata = gate_mem[gate_num];
		else
			prdata = '0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			sizes_q <= '0;
		else if (wr_en && hit_sizes)
			sizes_q <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (wr_en && hit_gate)
			gate_mem[gate_num] <= wr_word;
		rd.gate_word <= gate_mem[rd.gate_addr];  // Registered fetch for the controller
	end

	assign rd.input_count  = sizes_q.sizes.input_count;
	assign rd.gate_count   = sizes_q.sizes.gate_count;
	assign rd.output_count = sizes_q.sizes.output_count;
endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/gc_pkg.sv
hdl/gate_read_if.sv
hdl/netlist_regs.sv
hdl/label_gen.sv
hdl/label_ram.sv
hdl/garble_ctrl.sv
hdl/free_xor_garbler.sv
testbench/tb_free_xor_garbler.sv

// File: testbench/golden_vectors.txt
// Columns kind f1 f2 f3 in hex. Kind 1 APB write (addr data err), 2 APB read (addr data err)
// Kind 3 stream record (tag index0 data0), 4 run with a refused write (addr data), 0 end
1 000 00002103 0
1 100 00008300 0
1 104 00018401 0
1 108 00000106 0
1 10C 00010404 0
1 200 12345678 1
2 000 00002103 0
2 104 00018401 0
2 10C 00010404 0
2 004 00000000 1
4 104 0000DEAD 0
3 1 00 8EE395A3
3 5 00 C751CAD2
3 5 01 63A8E569
3 5 02 B1F472B7
3 2 00 A4F92FBB
3 2 01 9BEEC8AF
3 2 02 ED4B70CA
3 2 03 76A5B865
3 3 02 00000003
2 104 00018401 0
4 000 00000000 0
3 1 00 D8DA3959
3 5 00 6C6D1CAC
3 5 01 36368E56
3 5 02 1B1B472B
3 2 00 5A5B92FA
3 2 01 999AEC88
3 2 02 EEECB70F
3 2 03 77765B87
3 3 02 00000002
2 000 00002103 0
0 0 0 0

// File: testbench/tb_free_xor_garbler.sv
// Garbling core testbench
`timescale 1ns/1ps
`default_nettype none
`include "gc_defines.svh"

module tb_free_xor_garbler;
	localparam int CLK_PERIOD = 4;
	localparam int MAX_LINES  = 64;

	logic                      clk, rst;
	logic [`GC_APB_ADDR_W-1:0] paddr;
	logic                      psel, penable, pwrite;
	logic [`GC_WORD_W-1:0]     pwdata, prdata;
	logic                      pready, pslverr, start, busy;
	gc_pkg::stream_tag_e       tag;
	logic [`GC_IDX_W-1:0]      index0;
	logic [`GC_LABEL_W-1:0]    data0, data1;

	logic [31:0] vec [0:4*MAX_LINES-1];  // Four words per golden line
	logic [31:0] exp_tag [$];
	logic [31:0] exp_idx [$];
	logic [31:0] exp_data [$];
	logic [31:0] key_r;
	logic [31:0] cur_sizes;
	int unsigned lcg_state;
	int          checks, errors, rec_num, budget;
	logic        in_run;

	free_xor_garbler UUT (.clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
		.pready, .pslverr, .start, .busy, .tag, .index0, .data0, .data1);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// LCG draw of an idle gap from 0 to 3 cycles
	function automatic int unsigned next_gap();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % 4;
	endfunction

	// Cycles from start to the MASK record
	function automatic int run_latency(input logic [31:0] sizes);
		return 3 + int'(sizes[5:0]) + 2 * int'(sizes[11:6]);
	endfunction

	function automatic string tag_name(input logic [31:0] t);
		case (t[2:0])
			gc_pkg::TAG_KEY:   return "key";
			gc_pkg::TAG_INPUT: return "input";
			gc_pkg::TAG_GATE:  return "gate";
			gc_pkg::TAG_MASK:  return "mask";
			default:           return "unknown";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic apb_transfer(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		paddr   = addr[`GC_APB_ADDR_W-1:0];
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1 penable = 1'b1;
		@(negedge clk);  // Access phase with zero wait
		rdata = prdata;
		err   = pslverr;
		assert (pready) else begin
			errors++;
			$display("pready low in the access phase at %h", addr);
		end
		if (!in_run)
			check_value("idle_tag", gc_pkg::TAG_NONE, 32'(tag));
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_step(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int unsigned gap;
		gap = next_gap();
		repeat (gap) @(posedge clk);
		if (gap != 0)
			#1;
		apb_transfer(wr, addr, wdata, rdata, err);
	endtask

	task automatic run_garbler(input logic [31:0] waddr, input logic [31:0] wdata);
		int          cycles;
		logic [31:0] rdata;
		logic        err;
		in_run = 1'b1;
		start  = 1'b1;
		fork
			begin
				@(posedge clk);
				#1 start = 1'b0;
				cycles = 1;
				while (busy) begin
					@(posedge clk);
					#1 cycles++;
				end
			end
			begin
				@(posedge clk);
				#1 apb_transfer(1'b1, waddr, wdata, rdata, err);
				checks++;
				assert (err) else begin
					errors++;
					$display("Write to %h during a run was accepted", waddr[11:0]);
				end
				start = 1'b1;  // Second start while busy
				@(posedge clk);
				#1 start = 1'b0;
			end
		join
		check_value("run_latency", run_latency(cur_sizes), cycles);
		in_run = 1'b0;
	endtask

	task automatic check_record();
		string       name;
		logic [31:0] t, idx, d;
		assert (exp_tag.size() != 0) else begin
			errors++;
			$display("Unexpected %s record with nothing left to match", tag_name(32'(tag)));
		end
		if (exp_tag.size() == 0)
			return;
		t    = exp_tag.pop_front();
		idx  = exp_idx.pop_front();
		d    = exp_data.pop_front();
		name = $sformatf("%s_%0d", tag_name(t), rec_num);
		rec_num++;
		check_value({name, "_tag"}, t, 32'(tag));
		check_value({name, "_index0"}, idx, 32'(index0));
		check_value({name, "_data0"}, d, data0);
		if (t[2:0] == gc_pkg::TAG_KEY)
			key_r = d;
		else if (t[2:0] == gc_pkg::TAG_INPUT || t[2:0] == gc_pkg::TAG_GATE)
			check_value({name, "_data1"}, d ^ key_r, data1);  // One-label is zero-label ^ R
		else if (t[2:0] == gc_pkg::TAG_MASK)
			check_value({name, "_busy"}, 32'd0, 32'(busy));
	endtask

	// Registered records sampled mid cycle
	always @(negedge clk) begin
		if (!rst && tag != gc_pkg::TAG_NONE)
			check_record();
	end

	task automatic load_vectors();
		logic [31:0] sizes;
		int          total;
		sizes = '0;
		total = 0;
		for (int k = 0; k < MAX_LINES; k++) begin
			case (vec[4*k])
				32'd1: begin
					total += 5;
					if (vec[4*k+1] == `GC_ADDR_SIZES && vec[4*k+3] == 0)
						sizes = vec[4*k+2];
				end
				32'd2: total += 5;
				32'd3: begin
					exp_tag.push_back(vec[4*k+1]);
					exp_idx.push_back(vec[4*k+2]);
					exp_data.push_back(vec[4*k+3]);
				end
				32'd4: total += run_latency(sizes) + 8;
				default: ;
			endcase
		end
		budget = total;
	endtask

	task automatic run_vectors();
		logic [31:0] kind, f1, f2, f3, rdata;
		logic        err;
		for (int k = 0; k < MAX_LINES; k++) begin
			kind = vec[4*k];
			f1   = vec[4*k+1];
			f2   = vec[4*k+2];
			f3   = vec[4*k+3];
			if (kind == 0)
				break;
			case (kind)
				32'd1: begin
					apb_step(1'b1, f1, f2, rdata, err);
					check_value($sformatf("apb_write_err@%h", f1[11:0]), f3, 32'(err));
					if (f1 == `GC_ADDR_SIZES && f3 == 0)
						cur_sizes = f2;
				end
				32'd2: begin
					apb_step(1'b0, f1, '0, rdata, err);
					check_value($sformatf("apb_read_err@%h", f1[11:0]), f3, 32'(err));
					if (f3 == 0)
						check_value($sformatf("apb_read@%h", f1[11:0]), f2, rdata);
				end
				32'd4: run_garbler(f1, f2);
				default: ;
			endcase
		end
	endtask

	initial begin
		wait (budget > 0);
		#(budget * 40 * CLK_PERIOD);
		$display("Timeout, the output stream did not finish");
		$display("Checks %0d, errors %0d", checks, errors);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		paddr     = '0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		pwdata    = '0;
		start     = 1'b0;
		in_run    = 1'b0;
		checks    = 0;
		errors    = 0;
		rec_num   = 0;
		budget    = 0;
		key_r     = '0;
		cur_sizes = '0;
		lcg_state = 51;
		for (int i = 0; i < 4*MAX_LINES; i++)
			vec[i] = '0;
		$readmemh("testbench/golden_vectors.txt", vec);
		load_vectors();
		assert (exp_tag.size() != 0) else begin
			errors++;
			$display("The golden file holds no stream records");
		end
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		run_vectors();
		repeat (4) @(posedge clk);
		assert (exp_tag.size() == 0) else begin
			errors++;
			$display("%0d expected records never arrived", exp_tag.size());
		end
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end
endmodule

`default_nettype wire
